// File: lcdController.f
+incdir+verilog
verilog/lcdPkg.sv
verilog/lcdCharFifo.sv
verilog/lcdNibbleWriter.sv
verilog/lcdPowerUpInit.sv
verilog/lcdCommandSequencer.sv
verilog/lcdController.sv
tests/lcdControllerTb.sv

// File: run.sh
#!/bin/sh
# Build and run the lcdController testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module lcdControllerTb \
	-f lcdController.f -o simLcd > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simLcd > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: tests/lcdControllerTb.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcdControllerTb
	import lcdPkg::*;
();
	// -------------------------------------------------------------------------
	// Run length
	// -------------------------------------------------------------------------
	localparam int initPushes = 20;                     // Burst while init runs
	localparam int idlePushes = 18;                     // Pushed once idle
	localparam int numPushes  = initPushes + idlePushes;
	localparam int numXfers   = 4 + 5 + 16 + 1 + 16 + 1 + 2;
	localparam int byteCyc    = 2 * (`LCD_SETUP_CYC + `LCD_PULSE_CYC + `LCD_HOLD_CYC)
		+ `LCD_GAP_CYC + `LCD_POST_CYC;
	localparam int timeoutCyc = (`LCD_POWERON_CYC + `LCD_INIT1_CYC + `LCD_INIT2_CYC
		+ `LCD_CLEAR_CYC + numXfers * byteCyc) * 11 / 10;  // Plus 10%

	typedef struct packed
	{
		logic [`LCD_BYTE_W-1:0] data;
		logic                   kept;   // Buffer had room
	} pushEntryT;

	typedef struct packed
	{
		logic                   rs;
		logic [`LCD_DATA_W-1:0] nib;
	} nibblePairT;

	logic                   Clock;
	logic                   rstN;
	logic                   charValid;
	logic [`LCD_BYTE_W-1:0] charData;
	logic                   full;
	logic                   idle;
	lcdBusT                 lcdBus;

	pushEntryT  pushTable [numPushes];
	nibblePairT expQ [$];
	string      expName [$];
	int         idleMark [2];    // Nibbles seen when idle is due
	int         seed;
	int         cycle;
	int         releaseCycle;
	int         riseCycle;
	int         fallCycle;
	int         nibIdx;
	int         idleRises;
	int         valueErrors;
	int         otherErrors;
	logic       prevE;
	logic       prevIdle;
	logic       seenRise;
	nibblePairT curPair;

	lcdController dut0
	(
		.Clock     (Clock),
		.rstN      (rstN),
		.charValid (charValid),
		.charData  (charData),
		.full      (full),
		.idle      (idle),
		.lcdBus    (lcdBus)
	);

	initial
		Clock = 1'b0;
	always #10 Clock = ~Clock;    // 50 MHz

	// Cycle count and run limit
	always @(posedge Clock)
	begin
		cycle <= cycle + 1;
		if (cycle >= timeoutCyc)
		begin
			$display("Timeout after %0d cycles, %0d value errors, %0d other errors",
				cycle, valueErrors, otherErrors);
			$display("Simulation failed");
			$finish;
		end
	end

	// -------------------------------------------------------------------------
	// Expected nibble list
	// -------------------------------------------------------------------------
	task automatic addNibble(input logic isData, input logic [3:0] nib, input string name);
		nibblePairT p;
		p.rs  = isData;
		p.nib = nib;
		expQ.push_back(p);
		expName.push_back(name);
	endtask

	task automatic addByte(input logic isData, input logic [7:0] value, input string name);
		addNibble(isData, value[7:4], {name, " hi"});   // High nibble first
		addNibble(isData, value[3:0], {name, " lo"});
	endtask

	task automatic buildTables();
		logic [31:0] randWord;
		int          cursor;
		int          kept;
		cursor = 0;
		kept   = 0;
		for (int i = 0; i < numPushes; i++)
		begin
			randWord          = $random(seed);
			pushTable[i].data = randWord[7:0];
			// Tail of the init burst hits a full buffer
			pushTable[i].kept = (i >= `LCD_FIFO_DEPTH && i < initPushes) ? 1'b0 : 1'b1;
		end
		addNibble(1'b0, 4'h3, "wake 1");
		addNibble(1'b0, 4'h3, "wake 2");
		addNibble(1'b0, 4'h3, "wake 3");
		addNibble(1'b0, 4'h2, "wake 4");       // 4-bit mode
		addByte(1'b0, `LCD_CMD_FUNCSET, "function set");
		addByte(1'b0, `LCD_CMD_ENTRY, "entry mode");
		addByte(1'b0, `LCD_CMD_DISPLAY, "display on");
		addByte(1'b0, `LCD_CMD_CLEAR, "clear");
		addByte(1'b0, `LCD_ADDR_LINE1, "home address");
		for (int i = 0; i < numPushes; i++)
		begin
			if (i == initPushes)
				idleMark[0] = expQ.size();
			if (pushTable[i].kept)
			begin
				if (cursor == 16)
					addByte(1'b0, `LCD_ADDR_LINE2, "line 2 address");
				else if (cursor == 0 && kept != 0)
					addByte(1'b0, `LCD_ADDR_LINE1, "line 1 address");  // After wrap
				addByte(1'b1, pushTable[i].data, $sformatf("char %0d", i));
				cursor = (cursor + 1) % 32;
				kept++;
			end
		end
		idleMark[1] = expQ.size();
	endtask

	task automatic checkNibble(input nibblePairT got);
		assert (nibIdx < expQ.size())
		else
		begin
			$display("Extra E pulse after the last expected nibble, rs=%0b nibble=%h",
				got.rs, got.nib);
			otherErrors++;
		end
		if (nibIdx < expQ.size())
		begin
			assert (got == expQ[nibIdx])
			else
			begin
				$display("[FAIL] %s: expected rs=%0b nibble=%h, actual rs=%0b nibble=%h",
					expName[nibIdx], expQ[nibIdx].rs, expQ[nibIdx].nib, got.rs, got.nib);
				valueErrors++;
			end
		end
		nibIdx++;
	endtask

	task automatic checkIdleRise();
		assert (idleRises < 2)
		else
		begin
			$display("idle rose again although no characters were pending");
			otherErrors++;
		end
		if (idleRises < 2)
		begin
			// All kept characters written means the buffer has drained
			assert (nibIdx == idleMark[idleRises])
			else
			begin
				$display("[FAIL] idle rise %0d nibbles: expected %0d, actual %0d",
					idleRises, idleMark[idleRises], nibIdx);
				valueErrors++;
			end
		end
		idleRises++;
	endtask

	// -------------------------------------------------------------------------
	// Pin monitor, sampled mid-cycle
	// -------------------------------------------------------------------------
	always @(negedge Clock)
	begin
		if (rstN)
		begin
			assert (lcdBus.rw == 1'b0)
			else
			begin
				$display("RW went high at cycle %0d, reads are never issued", cycle);
				otherErrors++;
			end
			if (lcdBus.e && !prevE)
			begin
				riseCycle = cycle;
				curPair   = {lcdBus.rs, lcdBus.data};
				if (seenRise)
				begin
					assert (cycle - fallCycle >= `LCD_GAP_CYC)
					else
					begin
						$display("E pulses only %0d cycles apart at cycle %0d",
							cycle - fallCycle, cycle);
						otherErrors++;
					end
				end
				else
				begin
					assert (cycle - releaseCycle >= `LCD_POWERON_CYC)
					else
					begin
						$display("First E pulse came %0d cycles after reset, too early",
							cycle - releaseCycle);
						otherErrors++;
					end
				end
				seenRise = 1'b1;
			end
			if (!lcdBus.e && prevE)
			begin
				fallCycle = cycle;
				assert (cycle - riseCycle >= `LCD_PULSE_CYC)
				else
				begin
					$display("E high for only %0d cycles at cycle %0d", cycle - riseCycle, cycle);
					otherErrors++;
				end
				checkNibble(curPair);
			end
			if (idle && !prevIdle)
				checkIdleRise();
			prevE    = lcdBus.e;
			prevIdle = idle;
		end
	end

	// -------------------------------------------------------------------------
	// Stimulus
	// -------------------------------------------------------------------------
	initial
	begin
		seed        = 32'h673f;
		cycle       = 0;
		nibIdx      = 0;
		idleRises   = 0;
		valueErrors = 0;
		otherErrors = 0;
		prevE       = 1'b0;
		prevIdle    = 1'b0;
		seenRise    = 1'b0;
		rstN        = 1'b0;
		charValid   = 1'b0;
		charData    = '0;
		buildTables();
		repeat (3) @(negedge Clock);
		rstN         = 1'b1;
		releaseCycle = cycle;
		@(negedge Clock);
		assert (!lcdBus.e && !lcdBus.rs && !lcdBus.rw && !full && !idle)
		else
		begin
			$display("[FAIL] reset levels: expected e rs rw full idle = 00000, actual %b%b%b%b%b",
				lcdBus.e, lcdBus.rs, lcdBus.rw, full, idle);
			valueErrors++;
		end

		// Burst during init, buffer fills at 16
		for (int i = 0; i < initPushes; i++)
		begin
			charValid = 1'b1;
			charData  = pushTable[i].data;
			@(negedge Clock);
			assert (full == (i >= `LCD_FIFO_DEPTH - 1))
			else
			begin
				$display("[FAIL] full after push %0d: expected %0b, actual %0b",
					i + 1, (i >= `LCD_FIFO_DEPTH - 1), full);
				valueErrors++;
			end
		end
		charValid = 1'b0;
		while (!idle)
			@(negedge Clock);

		// Second batch, host holds off while full
		for (int i = initPushes; i < numPushes; i++)
		begin
			while (full)
				@(negedge Clock);
			charValid = 1'b1;
			charData  = pushTable[i].data;
			@(negedge Clock);
			charValid = 1'b0;
		end
		while (!idle)
			@(negedge Clock);
		@(negedge Clock);

		assert (nibIdx == expQ.size())
		else
		begin
			$display("[FAIL] nibble count: expected %0d, actual %0d", expQ.size(), nibIdx);
			valueErrors++;
		end
		assert (idleRises == 2)
		else
		begin
			$display("[FAIL] idle rises: expected 2, actual %0d", idleRises);
			valueErrors++;
		end
		$display("Run ended with %0d value errors and %0d other errors",
			valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog/lcdCharFifo.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcdCharFifo
(
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic                   push,
	input  logic [`LCD_BYTE_W-1:0] pushData,
	input  logic                   pop,
	output logic [`LCD_BYTE_W-1:0] headData,
	output logic                   empty,
	output logic                   full
);
	localparam int ptrW = $clog2(`LCD_FIFO_DEPTH);

	logic [`LCD_BYTE_W-1:0] mem [`LCD_FIFO_DEPTH];
	logic [ptrW-1:0]        wrPtr;
	logic [ptrW-1:0]        rdPtr;
	logic [ptrW:0]          count;    // One extra bit to tell full from empty
	logic                   doPush;
	logic                   doPop;

	assign doPush   = push && !full;    // Push while full is dropped
	assign doPop    = pop && !empty;
	assign empty    = (count == '0);
	assign full     = (count == (ptrW + 1)'(`LCD_FIFO_DEPTH));
	assign headData = mem[rdPtr];       // Oldest entry, show-ahead

	// Pointers and occupancy
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;  // Wraps at depth, power of two
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge Clock)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule

// File: verilog/lcdCommandSequencer.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcdCommandSequencer
	import lcdPkg::*;
(
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic                   empty,
	input  logic [`LCD_BYTE_W-1:0] headData,
	input  logic                   wrBusy,
	input  logic                   wrDone,
	output logic                   pop,
	output lcdReqT                 req,
	output logic                   start,
	output logic                   idle
);
	localparam int clrW = $clog2(`LCD_CLEAR_CYC);

	typedef enum logic [2:0]
	{
		sqInit, sqConfig, sqConfigWait, sqClearWait, sqWrite, sqXferWait
	} seqStateT;

	seqStateT               state;
	lcdReqT                 initReq;
	logic                   initStart;
	logic                   initDone;
	lcdReqT                 seqReq;
	logic                   seqStart;
	logic [1:0]             cfgIdx;     // Config command index
	logic [`LCD_BYTE_W-1:0] cfgByte;
	logic [`LCD_BYTE_W-1:0] addrByte;
	logic [clrW-1:0]        clrCnt;
	logic                   clrLast;
	logic [4:0]             cursor;     // 0..15 line one, 16..31 line two
	logic                   needAddr;   // Line address due before next char
	logic                   canSend;

	lcdPowerUpInit powerUp0
	(
		.Clock     (Clock),
		.rstN      (rstN),
		.wrDone    (wrDone),
		.initReq   (initReq),
		.initStart (initStart),
		.initDone  (initDone)
	);

	// Init drives the writer until it is done
	assign req   = initDone ? seqReq : initReq;
	assign start = initDone ? seqStart : initStart;

	always_comb
	begin
		case (cfgIdx)
			2'd0:    cfgByte = `LCD_CMD_FUNCSET;
			2'd1:    cfgByte = `LCD_CMD_ENTRY;
			2'd2:    cfgByte = `LCD_CMD_DISPLAY;
			default: cfgByte = `LCD_CMD_CLEAR;
		endcase
	end

	assign addrByte = cursor[4] ? `LCD_ADDR_LINE2 : `LCD_ADDR_LINE1;
	assign clrLast  = (clrCnt == clrW'(`LCD_CLEAR_CYC - 1));
	assign canSend  = (state == sqWrite) && !empty && !wrBusy;
	assign pop      = canSend && !needAddr;              // Address goes first
	assign idle     = (state == sqWrite) && empty && !wrBusy;

	// -------------------------------------------------------------------------
	// Config, clear, then character writes
	// -------------------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			state    <= sqInit;
			cfgIdx   <= 2'd0;
			clrCnt   <= '0;
			cursor   <= '0;
			needAddr <= 1'b0;
			seqStart <= 1'b0;
		end
		else
		begin
			seqStart <= 1'b0;
			case (state)
				sqInit: if (initDone) state <= sqConfig;
				sqConfig:
				begin
					seqStart <= 1'b1;
					state    <= sqConfigWait;
				end
				sqConfigWait:
				begin
					if (wrDone && cfgIdx == 2'd3)
						state <= sqClearWait;            // Clear sent
					else if (wrDone)
					begin
						cfgIdx <= cfgIdx + 1'b1;
						state  <= sqConfig;
					end
				end
				sqClearWait:
				begin
					clrCnt <= clrCnt + 1'b1;
					if (clrLast)
					begin
						seqStart <= 1'b1;                // Line one address
						state    <= sqXferWait;
					end
				end
				sqWrite:
				begin
					if (canSend)
					begin
						seqStart <= 1'b1;
						state    <= sqXferWait;
						if (needAddr)
							needAddr <= 1'b0;
						else
						begin
							cursor   <= cursor + 1'b1;   // Wraps 31 to 0
							needAddr <= (cursor == 5'd15) || (cursor == 5'd31);
						end
					end
				end
				sqXferWait: if (wrDone) state <= sqWrite;
				default:    state <= sqInit;
			endcase
		end
	end

	// Request payload
	always_ff @(posedge Clock)
	begin
		if (state == sqConfig)
			seqReq <= '{rs: 1'b0, nibbleOnly: 1'b0, value: cfgByte};
		else if (state == sqClearWait && clrLast)
			seqReq <= '{rs: 1'b0, nibbleOnly: 1'b0, value: `LCD_ADDR_LINE1};
		else if (canSend)
			seqReq <= '{rs: !needAddr, nibbleOnly: 1'b0, value: needAddr ? addrByte : headData};
	end

endmodule

// File: verilog/lcdController.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcdController
	import lcdPkg::*;
(
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic                   charValid,   // Push strobe
	input  logic [`LCD_BYTE_W-1:0] charData,
	output logic                   full,
	output logic                   idle,
	output lcdBusT                 lcdBus
);
	// Buffer to sequencer
	logic                   empty;
	logic [`LCD_BYTE_W-1:0] headData;
	logic                   pop;
	// Sequencer to writer
	lcdReqT                 req;
	logic                   start;
	logic                   wrBusy;
	logic                   wrDone;

	lcdCharFifo charFifo0
	(
		.Clock    (Clock),
		.rstN     (rstN),
		.push     (charValid),
		.pushData (charData),
		.pop      (pop),
		.headData (headData),
		.empty    (empty),
		.full     (full)
	);

	lcdCommandSequencer seq0
	(
		.Clock    (Clock),
		.rstN     (rstN),
		.empty    (empty),
		.headData (headData),
		.wrBusy   (wrBusy),
		.wrDone   (wrDone),
		.pop      (pop),
		.req      (req),
		.start    (start),
		.idle     (idle)
	);

	lcdNibbleWriter writer0
	(
		.Clock  (Clock),
		.rstN   (rstN),
		.start  (start),
		.req    (req),
		.busy   (wrBusy),
		.done   (wrDone),
		.lcdBus (lcdBus)
	);

endmodule

// File: verilog/lcdNibbleWriter.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcdNibbleWriter
	import lcdPkg::*;
(
	input  logic   Clock,
	input  logic   rstN,
	input  logic   start,
	input  lcdReqT req,
	output logic   busy,
	output logic   done,
	output lcdBusT lcdBus
);
	localparam int cntW = $clog2(`LCD_POST_CYC);   // Longest wait here

	typedef enum logic [2:0] {stIdle, stSetup, stPulse, stHold, stGap, stPost} wrStateT;

	wrStateT                state;
	lcdReqT                 cur;        // Request taken on start
	logic                   lowPhase;   // Second nibble of a byte
	logic [cntW-1:0]        cnt;
	logic [cntW-1:0]        waitLen;
	logic                   lastCycle;
	logic                   lastNibble;
	logic [`LCD_DATA_W-1:0] nibble;
	lcdBusT                 busNext;

	// Length of the current phase
	always_comb
	begin
		case (state)
			stPulse: waitLen = cntW'(`LCD_PULSE_CYC);
			stHold:  waitLen = cntW'(`LCD_HOLD_CYC);
			stGap:   waitLen = cntW'(`LCD_GAP_CYC);
			stPost:  waitLen = cntW'(`LCD_POST_CYC);
			default: waitLen = cntW'(`LCD_SETUP_CYC);
		endcase
	end

	assign lastCycle  = (cnt == waitLen - 1'b1);
	assign lastNibble = lowPhase || cur.nibbleOnly;
	assign nibble     = lastNibble ? cur.value.nib.lo : cur.value.nib.hi;
	assign busy       = (state != stIdle);   // Rises the cycle after start

	// -------------------------------------------------------------------------
	// Phase sequencing
	// -------------------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			state    <= stIdle;
			cnt      <= '0;
			lowPhase <= 1'b0;
			done     <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (state == stIdle || lastCycle)
				cnt <= '0;                    // Restart per phase
			else
				cnt <= cnt + 1'b1;

			case (state)
				stIdle:
				begin
					if (start)
					begin
						state    <= stSetup;
						lowPhase <= 1'b0;
					end
				end
				stSetup: if (lastCycle) state <= stPulse;
				stPulse: if (lastCycle) state <= stHold;
				stHold:  if (lastCycle) state <= lastNibble ? stPost : stGap;
				stGap:
				begin
					if (lastCycle)
					begin
						state    <= stSetup;      // Low nibble next
						lowPhase <= 1'b1;
					end
				end
				stPost:
				begin
					if (lastCycle)
					begin
						state <= stIdle;          // busy falls with done
						done  <= 1'b1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Capture request
	always_ff @(posedge Clock)
	begin
		if (state == stIdle && start)
			cur <= req;
	end

	// Pin decode, registered so E is glitch free
	always_comb
	begin
		busNext = '0;                         // RW low always
		if (state == stSetup || state == stPulse || state == stHold)
		begin
			busNext.rs   = cur.rs;
			busNext.data = nibble;
			busNext.e    = (state == stPulse);
		end
	end

	always_ff @(posedge Clock)
	begin
		if (!rstN)
			lcdBus <= '0;
		else
			lcdBus <= busNext;
	end

endmodule

// File: verilog/lcdPkg.sv
`include "lcd_consts.svh"

package lcdPkg;

	// -------------------------------------------------------------------------
	// Transfer byte
	// -------------------------------------------------------------------------
	typedef struct packed
	{
		logic [`LCD_DATA_W-1:0] hi;   // Sent first
		logic [`LCD_DATA_W-1:0] lo;
	} lcdNibblesT;

	// Same byte, whole for the command side, split for the pins
	typedef union packed
	{
		logic [`LCD_BYTE_W-1:0] whole;
		lcdNibblesT             nib;
	} lcdByteU;

	// Write request to the nibble writer
	typedef struct packed
	{
		logic    rs;          // 0 command, 1 character data
		logic    nibbleOnly;  // Init nibbles, value.lo only
		lcdByteU value;
	} lcdReqT;

	// Pin levels
	typedef struct packed
	{
		logic                   e;
		logic                   rs;
		logic                   rw;   // Tied low, no reads
		logic [`LCD_DATA_W-1:0] data;
	} lcdBusT;

endpackage

// File: verilog/lcdPowerUpInit.sv
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcdPowerUpInit
	import lcdPkg::*;
(
	input  logic   Clock,
	input  logic   rstN,
	input  logic   wrDone,
	output lcdReqT initReq,
	output logic   initStart,
	output logic   initDone
);
	localparam int cntW = $clog2(`LCD_POWERON_CYC);  // 15 ms is the longest

	typedef enum logic [2:0] {ipPowerOn, ipStart, ipBusy, ipDelay, ipDone} initStateT;

	initStateT       state;
	logic [1:0]      step;       // Wake-up nibble 0..3
	logic [cntW-1:0] cnt;
	logic [cntW-1:0] waitLen;
	logic            lastCycle;

	// Wait after each step
	always_comb
	begin
		if (state == ipPowerOn)
			waitLen = cntW'(`LCD_POWERON_CYC);
		else if (step == 2'd0)
			waitLen = cntW'(`LCD_INIT1_CYC);
		else if (step == 2'd1)
			waitLen = cntW'(`LCD_INIT2_CYC);
		else
			waitLen = cntW'(1);    // Writer post wait covers the third nibble
	end

	assign lastCycle = (cnt == waitLen - 1'b1);

	// -------------------------------------------------------------------------
	// Wake-up sequence 3, 3, 3, 2
	// -------------------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			state <= ipPowerOn;
			step  <= 2'd0;
			cnt   <= '0;
		end
		else
		begin
			if ((state == ipPowerOn || state == ipDelay) && !lastCycle)
				cnt <= cnt + 1'b1;
			else
				cnt <= '0;

			case (state)
				ipPowerOn: if (lastCycle) state <= ipStart;
				ipStart:   state <= ipBusy;          // One-cycle start
				ipBusy:
				begin
					if (wrDone)
						state <= (step == 2'd3) ? ipDone : ipDelay;
				end
				ipDelay:
				begin
					if (lastCycle)
					begin
						step  <= step + 1'b1;
						state <= ipStart;
					end
				end
				default: state <= ipDone;            // Stays here
			endcase
		end
	end

	assign initStart = (state == ipStart);
	assign initDone  = (state == ipDone);

	// Command nibbles, rs low
	always_comb
	begin
		initReq              = '0;
		initReq.nibbleOnly   = 1'b1;
		initReq.value.nib.lo = (step == 2'd3) ? 4'h2 : 4'h3;  // Last one selects 4-bit
	end

endmodule

// File: verilog/lcd_consts.svh
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// -------------------------------------------------------------------------
// Bus and buffer sizes
// -------------------------------------------------------------------------
`define LCD_DATA_W      4       // DB7..DB4 only, 4-bit mode
`define LCD_BYTE_W      8
`define LCD_FIFO_DEPTH  16      // One display line

// -------------------------------------------------------------------------
// Waits in Clock cycles, 50 MHz
// -------------------------------------------------------------------------
`define LCD_SETUP_CYC   2       // Data stable before E rises
`define LCD_PULSE_CYC   12      // E high width, 240 ns
`define LCD_HOLD_CYC    2       // Data held after E falls
`define LCD_GAP_CYC     50      // 1 us between nibbles
`define LCD_POST_CYC    2000    // 40 us after each transfer
`define LCD_POWERON_CYC 750000  // 15 ms
`define LCD_INIT1_CYC   205000  // 4.1 ms
`define LCD_INIT2_CYC   5000    // 100 us
`define LCD_CLEAR_CYC   82000   // 1.64 ms on top of the post wait

// Command bytes
`define LCD_CMD_FUNCSET 8'h28   // 4-bit, 2 lines, 5x8 font
`define LCD_CMD_ENTRY   8'h06   // Increment, no shift
`define LCD_CMD_DISPLAY 8'h0C   // Display on, cursor off
`define LCD_CMD_CLEAR   8'h01
`define LCD_ADDR_LINE1  8'h80   // DDRAM 0x00
`define LCD_ADDR_LINE2  8'hC0   // DDRAM 0x40

`endif
